/* hdl/cpu_pkg.sv */
package cpu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_COUNT  = 32;
  localparam int PC_W       = 8;   // Word-addressed PC
  localparam int DMEM_WORDS = 16;
  localparam int DMEM_AW    = 4;

  // Opcodes, bits 31..26
  localparam logic [5:0] OP_RTYPE = 6'b000000;
  localparam logic [5:0] OP_LW    = 6'b100011;
  localparam logic [5:0] OP_SW    = 6'b101011;
  localparam logic [5:0] OP_BEQ   = 6'b000100;

  // R-type funct, bits 5..0
  localparam logic [5:0] FN_ADD = 6'b100000;
  localparam logic [5:0] FN_SUB = 6'b100010;
  localparam logic [5:0] FN_AND = 6'b100100;
  localparam logic [5:0] FN_OR  = 6'b100101;
  localparam logic [5:0] FN_SLT = 6'b101010;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [PC_W-1:0] pc_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    FWD_RF,      // Register file value
    FWD_EX_MEM,
    FWD_MEM_WB
  } fwd_sel_e;

  // All zero means bubble
  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src;
    logic    branch;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    pc_t    pc_plus1;
    instr_t instr;
  } if_id_t;

  typedef struct packed {
    ctrl_t     ctrl;
    pc_t       pc_plus1;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm;      // Already sign-extended
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
  } id_ex_t;

  typedef struct packed {
    ctrl_t     ctrl;
    word_t     alu_result;
    word_t     store_data;
    reg_addr_t dest;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t dest;
    word_t     result;
  } mem_wb_t;

  // Register write bus, also the retirement trace
  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

/* hdl/pipe_stage_reg.sv */
`timescale 1ns/1ps

module pipe_stage_reg
  import cpu_pkg::*;
#(
  parameter type payload_t = if_id_t
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     hold,   // Keep current contents
  input  logic     flush,  // Load a bubble, wins over hold
  input  payload_t d,
  output payload_t q
);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      q <= '0;
    end else if (flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/1ps

module reg_file
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  reg_addr_t rs,
  input  reg_addr_t rt,
  output word_t     rs_data,
  output word_t     rt_data,
  input  wb_t       wb
);

  word_t regs [REG_COUNT];

  // Same-cycle write is visible to the ID read
  function automatic word_t read_port(input reg_addr_t addr);
    if (addr == '0)
      return '0;
    else if (wb.valid && wb.rd == addr)
      return wb.data;
    else
      return regs[addr];
  endfunction

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < REG_COUNT; i++)
        regs[i] <= word_t'(i);  // Register i starts at i
    end else if (wb.valid) begin
      regs[wb.rd] <= wb.data;
    end
  end

  assign rs_data = read_port(rs);
  assign rt_data = read_port(rt);

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode
  import cpu_pkg::*;
(
  input  if_id_t    if_id,
  output reg_addr_t rs,
  output reg_addr_t rt,
  input  word_t     rs_data,
  input  word_t     rt_data,
  output id_ex_t    id_ex
);

  logic [5:0]   opcode;
  logic [5:0]   funct;
  reg_addr_t    rd;
  logic [15:0]  imm16;
  word_t        imm_ext;
  ctrl_t        dec_ctrl;
  reg_addr_t    dec_dest;
  logic         fn_ok;

  // Standard MIPS field positions
  assign opcode = if_id.instr[31:26];
  assign rs     = if_id.instr[25:21];
  assign rt     = if_id.instr[20:16];
  assign rd     = if_id.instr[15:11];
  assign funct  = if_id.instr[5:0];
  assign imm16  = if_id.instr[15:0];

  assign imm_ext = {{(XLEN-16){imm16[15]}}, imm16};

  always_comb begin
    dec_ctrl = '0;
    dec_dest = '0;
    fn_ok    = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        fn_ok = 1'b1;
        case (funct)
          FN_ADD:  dec_ctrl.alu_op = ALU_ADD;
          FN_SUB:  dec_ctrl.alu_op = ALU_SUB;
          FN_AND:  dec_ctrl.alu_op = ALU_AND;
          FN_OR:   dec_ctrl.alu_op = ALU_OR;
          FN_SLT:  dec_ctrl.alu_op = ALU_SLT;
          default: fn_ok = 1'b0;  // Includes the all-zero word
        endcase
        dec_ctrl.reg_write = fn_ok;
        dec_dest           = fn_ok ? rd : '0;
      end
      OP_LW: begin
        dec_ctrl.reg_write  = 1'b1;
        dec_ctrl.mem_read   = 1'b1;
        dec_ctrl.mem_to_reg = 1'b1;
        dec_ctrl.alu_src    = 1'b1;
        dec_ctrl.alu_op     = ALU_ADD;  // Base plus offset
        dec_dest            = rt;
      end
      OP_SW: begin
        dec_ctrl.mem_write = 1'b1;
        dec_ctrl.alu_src   = 1'b1;
        dec_ctrl.alu_op    = ALU_ADD;
      end
      OP_BEQ: begin
        dec_ctrl.branch = 1'b1;
        dec_ctrl.alu_op = ALU_SUB;
      end
      default: ;  // Unknown opcode stays a bubble
    endcase
  end

  assign id_ex = '{
    ctrl:     dec_ctrl,
    pc_plus1: if_id.pc_plus1,
    rs_data:  rs_data,
    rt_data:  rt_data,
    imm:      imm_ext,
    rs:       rs,
    rt:       rt,
    dest:     dec_dest
  };

endmodule

/* hdl/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit
  import cpu_pkg::*;
(
  input  id_ex_t   id_ex,
  input  fwd_sel_e fwd_a,
  input  fwd_sel_e fwd_b,
  input  word_t    ex_mem_result,
  input  word_t    wb_result,
  output ex_mem_t  ex_mem,
  output logic     branch_taken,
  output pc_t      branch_target
);

  word_t op_a;
  word_t rt_fwd;   // Forwarded rt, also the store data
  word_t op_b;
  word_t alu_out;

  function automatic word_t fwd_mux(input fwd_sel_e sel, input word_t rf_val);
    case (sel)
      FWD_EX_MEM: return ex_mem_result;
      FWD_MEM_WB: return wb_result;
      default:    return rf_val;
    endcase
  endfunction

  assign op_a   = fwd_mux(fwd_a, id_ex.rs_data);
  assign rt_fwd = fwd_mux(fwd_b, id_ex.rt_data);
  assign op_b   = id_ex.ctrl.alu_src ? id_ex.imm : rt_fwd;

  always_comb begin
    case (id_ex.ctrl.alu_op)
      ALU_SUB: alu_out = op_a - op_b;
      ALU_AND: alu_out = op_a & op_b;
      ALU_OR:  alu_out = op_a | op_b;
      ALU_SLT: alu_out = word_t'($signed(op_a) < $signed(op_b));
      default: alu_out = op_a + op_b;
    endcase
  end

  // beq resolves here in EX
  assign branch_taken  = id_ex.ctrl.branch && (op_a == rt_fwd);
  assign branch_target = id_ex.pc_plus1 + id_ex.imm[PC_W-1:0];

  assign ex_mem = '{
    ctrl:       id_ex.ctrl,
    alu_result: alu_out,
    store_data: rt_fwd,
    dest:       id_ex.dest
  };

endmodule

/* hdl/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
  import cpu_pkg::*;
(
  input  reg_addr_t id_rs,
  input  reg_addr_t id_rt,
  input  id_ex_t    id_ex,
  input  ex_mem_t   ex_mem,
  input  mem_wb_t   mem_wb,
  input  logic      branch_taken,
  output fwd_sel_e  fwd_a,
  output fwd_sel_e  fwd_b,
  output logic      stall,
  output logic      flush
);

  logic ex_mem_writes;
  logic mem_wb_writes;
  logic load_in_ex;

  // r0 is never a forwarding source
  assign ex_mem_writes = ex_mem.ctrl.reg_write && (ex_mem.dest != '0);
  assign mem_wb_writes = mem_wb.reg_write && (mem_wb.dest != '0);

  // Younger result wins
  function automatic fwd_sel_e pick_source(input reg_addr_t src);
    if (ex_mem_writes && ex_mem.dest == src)
      return FWD_EX_MEM;
    else if (mem_wb_writes && mem_wb.dest == src)
      return FWD_MEM_WB;
    else
      return FWD_RF;
  endfunction

  assign fwd_a = pick_source(id_ex.rs);
  assign fwd_b = pick_source(id_ex.rt);

  // Load data only exists after MEM, so a direct consumer waits one cycle
  assign load_in_ex = id_ex.ctrl.mem_read && (id_ex.dest != '0);
  assign stall      = load_in_ex && (id_ex.dest == id_rs || id_ex.dest == id_rt);

  // Taken branch kills the two younger instructions
  assign flush = branch_taken;

endmodule

/* hdl/data_memory.sv */
`timescale 1ns/1ps

module data_memory
  import cpu_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  ex_mem_t ex_mem,
  output mem_wb_t mem_wb
);

  word_t              mem [DMEM_WORDS];
  logic [DMEM_AW-1:0] addr;

  assign addr = ex_mem.alu_result[DMEM_AW-1:0];  // Word index, upper bits ignored

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < DMEM_WORDS; i++)
        mem[i] <= '0;
    end else if (ex_mem.ctrl.mem_write) begin
      mem[addr] <= ex_mem.store_data;
    end
  end

  assign mem_wb.reg_write = ex_mem.ctrl.reg_write;
  assign mem_wb.dest      = ex_mem.dest;
  assign mem_wb.result    = ex_mem.ctrl.mem_to_reg ? mem[addr] : ex_mem.alu_result;

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
(
  input  logic   clk,
  input  logic   rst,
  output pc_t    imem_addr,
  input  instr_t imem_data,
  output wb_t    wb
);

  pc_t       pc;
  pc_t       pc_plus1;
  if_id_t    if_id_d, if_id_q;
  id_ex_t    id_ex_d, id_ex_q;
  ex_mem_t   ex_mem_d, ex_mem_q;
  mem_wb_t   mem_wb_d, mem_wb_q;
  reg_addr_t id_rs, id_rt;
  word_t     rs_data, rt_data;
  fwd_sel_e  fwd_a, fwd_b;
  logic      stall;
  logic      flush;
  logic      branch_taken;
  pc_t       branch_target;

  assign pc_plus1  = pc + 1'b1;
  assign imem_addr = pc;

  // Branch redirect has priority over the load-use hold
  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      pc <= '0;
    else if (branch_taken)
      pc <= branch_target;
    else if (!stall)
      pc <= pc_plus1;
  end

  assign if_id_d = '{pc_plus1: pc_plus1, instr: imem_data};

  pipe_stage_reg #(.payload_t(if_id_t)) if_id_reg (
    .clk(clk), .rst(rst), .hold(stall), .flush(flush),
    .d(if_id_d), .q(if_id_q)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst), .rs(id_rs), .rt(id_rt),
    .rs_data(rs_data), .rt_data(rt_data), .wb(wb)
  );

  instr_decode u_decode (
    .if_id(if_id_q), .rs(id_rs), .rt(id_rt),
    .rs_data(rs_data), .rt_data(rt_data), .id_ex(id_ex_d)
  );

  // Stall inserts a bubble behind the load
  pipe_stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(flush | stall),
    .d(id_ex_d), .q(id_ex_q)
  );

  execute_unit u_execute (
    .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
    .ex_mem_result(ex_mem_q.alu_result), .wb_result(mem_wb_q.result),
    .ex_mem(ex_mem_d), .branch_taken(branch_taken), .branch_target(branch_target)
  );

  hazard_unit u_hazard (
    .id_rs(id_rs), .id_rt(id_rt), .id_ex(id_ex_q), .ex_mem(ex_mem_q),
    .mem_wb(mem_wb_q), .branch_taken(branch_taken),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .stall(stall), .flush(flush)
  );

  pipe_stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
    .d(ex_mem_d), .q(ex_mem_q)
  );

  data_memory u_dmem (
    .clk(clk), .rst(rst), .ex_mem(ex_mem_q), .mem_wb(mem_wb_d)
  );

  pipe_stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
    .clk(clk), .rst(rst), .hold(1'b0), .flush(1'b0),
    .d(mem_wb_d), .q(mem_wb_q)
  );

  // Writes to r0 never retire
  assign wb = '{
    valid: mem_wb_q.reg_write && (mem_wb_q.dest != '0),
    rd:    mem_wb_q.dest,
    data:  mem_wb_q.result
  };

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Released on a falling edge
  end

endmodule

/* sim/cpu_properties.sv */
`timescale 1ns/1ps

module cpu_properties
  import cpu_pkg::*;
(
  input logic clk,
  input logic rst,
  input pc_t  imem_addr,
  input wb_t  wb
);

  int unsigned fail_count = 0;  // Failure count, visible to the testbench
  logic [2:0]  settle;          // Cycles since reset release, stops at 4

  always_ff @(posedge clk or posedge rst) begin
    if (rst)
      settle <= '0;
    else if (settle != 3'd4)
      settle <= settle + 3'd1;
  end

  no_wb_in_reset: assert property (@(posedge clk) rst |-> !wb.valid)
    else begin
      $error("writeback beat while reset is asserted");
      fail_count = fail_count + 1;
    end

  pc_zero_in_reset: assert property (@(posedge clk) rst |-> imem_addr == '0)
    else begin
      $error("instruction address is not zero during reset");
      fail_count = fail_count + 1;
    end

  // Pipeline is still filling right after reset
  no_early_wb: assert property (@(posedge clk) (!rst && settle != 3'd4) |-> !wb.valid)
    else begin
      $error("writeback beat within four cycles of reset release");
      fail_count = fail_count + 1;
    end

  no_r0_write: assert property (@(posedge clk) wb.valid |-> wb.rd != '0)
    else begin
      $error("writeback beat targets register 0");
      fail_count = fail_count + 1;
    end

endmodule

bind cpu_top cpu_properties u_props (
  .clk(clk),
  .rst(rst),
  .imem_addr(imem_addr),
  .wb(wb)
);

/* sim/cpu_tb.sv */
`timescale 1ns/1ps

module cpu_tb
  import cpu_pkg::*;
();

  logic   clk;
  logic   rst;
  pc_t    imem_addr;
  instr_t imem_data;
  wb_t    wb;

  instr_t imem [256];
  int     prog_len;                      // Next free instruction address
  integer seed = 32'h9448adc1;
  word_t  model_regs [REG_COUNT];        // ISA reference state
  word_t  model_mem [DMEM_WORDS];
  wb_t    exp_q [$];                     // Expected writebacks in program order
  int     prog_ends [$];                 // Expected count at the end of each program
  string  prog_names [$];

  tb_clock u_clock (.clk(clk), .rst(rst));

  cpu_top DUT (
    .clk(clk), .rst(rst), .imem_addr(imem_addr), .imem_data(imem_data), .wb(wb)
  );

  assign imem_data = imem[imem_addr];  // Same-cycle fetch

  function automatic instr_t rtype_word(input logic [5:0] funct, input int rd, input int rs,
                                        input int rt);
    return {OP_RTYPE, reg_addr_t'(rs), reg_addr_t'(rt), reg_addr_t'(rd), 5'd0, funct};
  endfunction

  function automatic instr_t itype_word(input logic [5:0] op, input int rs, input int rt,
                                        input int imm);
    return {op, reg_addr_t'(rs), reg_addr_t'(rt), 16'(imm)};
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [5:0] random_funct();
    case (rand_below(5))
      0:       return FN_ADD;
      1:       return FN_SUB;
      2:       return FN_AND;
      3:       return FN_OR;
      default: return FN_SLT;
    endcase
  endfunction

  task automatic emit(input instr_t w);
    imem[prog_len[7:0]] = w;
    prog_len++;
  endtask

  task automatic record_write(input reg_addr_t rd, input word_t v);
    if (rd != '0) begin  // r0 stays zero and never retires
      model_regs[rd] = v;
      exp_q.push_back('{valid: 1'b1, rd: rd, data: v});
    end
  endtask

  // Executes the program one instruction at a time from start up to prog_len
  task automatic run_model(input int start);
    int     pc;
    instr_t w;
    word_t  a;
    word_t  b;
    word_t  imm;
    word_t  addr;
    pc = start;
    while (pc < prog_len) begin
      w    = imem[pc[7:0]];
      a    = model_regs[w[25:21]];
      b    = model_regs[w[20:16]];
      imm  = {{16{w[15]}}, w[15:0]};
      addr = a + imm;
      pc++;
      case (w[31:26])
        OP_RTYPE: begin
          case (w[5:0])
            FN_ADD:  record_write(w[15:11], a + b);
            FN_SUB:  record_write(w[15:11], a - b);
            FN_AND:  record_write(w[15:11], a & b);
            FN_OR:   record_write(w[15:11], a | b);
            FN_SLT:  record_write(w[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            default: ;
          endcase
        end
        OP_LW:   record_write(w[20:16], model_mem[addr[DMEM_AW-1:0]]);
        OP_SW:   model_mem[addr[DMEM_AW-1:0]] = b;
        OP_BEQ:  if (a == b) pc += int'($signed(imm));  // Relative to pc_plus1
        default: ;
      endcase
    end
  endtask

  task automatic end_program(input string name, input int start);
    run_model(start);
    prog_ends.push_back(exp_q.size());
    prog_names.push_back(name);
  endtask

  task automatic build_alu_chains();
    int start;
    start = prog_len;
    emit(rtype_word(FN_ADD, 8, 1, 2));
    emit(rtype_word(FN_SUB, 9, 8, 4));    // rs from EX/MEM
    emit(rtype_word(FN_AND, 10, 9, 8));   // Both forwarding paths at once
    emit(rtype_word(FN_OR, 11, 5, 10));   // rt from EX/MEM
    emit(rtype_word(FN_SUB, 12, 1, 6));   // -5
    emit(rtype_word(FN_SLT, 13, 12, 1));  // Negative below positive
    emit(rtype_word(FN_SLT, 14, 1, 12));
    emit(rtype_word(FN_ADD, 15, 13, 12));
    emit(rtype_word(FN_OR, 0, 15, 4));    // Write to r0 is dropped
    emit(rtype_word(FN_ADD, 16, 0, 15));  // r0 must not be forwarded
    end_program("ALU chains", start);
  endtask

  task automatic build_load_use();
    int start;
    start = prog_len;
    emit(itype_word(OP_SW, 0, 20, 3));
    emit(itype_word(OP_LW, 0, 17, 3));
    emit(rtype_word(FN_ADD, 18, 17, 4));  // Load-use on rs
    emit(itype_word(OP_LW, 1, 19, 2));
    emit(rtype_word(FN_SUB, 21, 2, 19));  // Load-use on rt
    end_program("load-use", start);
  endtask

  task automatic build_store_load();
    int start;
    start = prog_len;
    emit(rtype_word(FN_ADD, 22, 5, 6));
    emit(itype_word(OP_SW, 1, 22, 5));    // Store data forwarded from EX/MEM
    emit(itype_word(OP_LW, 0, 23, 6));
    emit(itype_word(OP_LW, 0, 24, 6));
    emit(itype_word(OP_SW, 0, 24, 7));    // Stores a value just loaded
    emit(itype_word(OP_LW, 0, 25, 7));
    emit(itype_word(OP_SW, 0, 3, -1));    // Wraps to word 15
    emit(itype_word(OP_LW, 3, 26, 12));
    end_program("store then load", start);
  endtask

  task automatic build_branches();
    int start;
    start = prog_len;
    emit(itype_word(OP_BEQ, 1, 1, 2));    // Taken
    emit(rtype_word(FN_ADD, 27, 1, 1));
    emit(rtype_word(FN_ADD, 28, 1, 1));
    emit(rtype_word(FN_ADD, 29, 1, 2));   // Target
    emit(itype_word(OP_BEQ, 1, 2, 2));    // Not taken
    emit(rtype_word(FN_ADD, 27, 2, 2));
    emit(rtype_word(FN_SUB, 30, 3, 3));
    emit(itype_word(OP_BEQ, 30, 0, 3));   // Taken on a forwarded zero
    emit(rtype_word(FN_ADD, 28, 3, 3));
    emit(rtype_word(FN_ADD, 28, 4, 4));
    emit(rtype_word(FN_ADD, 28, 5, 5));
    emit(rtype_word(FN_OR, 31, 30, 7));
    end_program("branches", start);
  endtask

  task automatic build_random();
    int start;
    start = prog_len;
    repeat (40) begin
      emit(rtype_word(random_funct(), 1 + rand_below(7), 1 + rand_below(7),
                      1 + rand_below(7)));
    end
    end_program("random R-type", start);
  endtask

  task automatic check_writeback();
    wb_t want;
    if (exp_q.size() == 0) begin
      $display("Unexpected writeback to r%0d with data %h at time %0t, none was expected",
               wb.rd, wb.data, $time);
      $display("=== FAIL ===");
      $fatal(1, "unexpected writeback");
    end else begin
      want = exp_q.pop_front();
      assert (wb.rd == want.rd && wb.data == want.data) else begin
        $display("Fail at time %0t: expected r%0d = %h, got r%0d = %h",
                 $time, want.rd, want.data, wb.rd, wb.data);
        $display("=== FAIL ===");
        $fatal(1, "writeback mismatch");
      end
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst && cycles < 40) begin
      @(posedge clk);
      cycles++;
    end
    if (rst) begin
      $display("Reset was never released");
      $display("=== FAIL ===");
      $fatal(1, "reset timeout");
    end
  endtask

  task automatic wait_drain(input string name, input int left);
    int cycles;
    cycles = 0;
    while (exp_q.size() > left && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() > left) begin
      $display("Timeout in program %s, these writebacks never arrived:", name);
      for (int i = 0; i < exp_q.size() - left; i++)
        $display("  r%0d = %h", exp_q[i].rd, exp_q[i].data);
      $display("=== FAIL ===");
      $fatal(1, "writeback timeout");
    end
  endtask

  // Mid-cycle look at the writeback bus
  always @(negedge clk) begin
    if (DUT.u_props.fail_count != 0) begin
      $display("A property bound to cpu_top failed at time %0t", $time);
      $display("=== FAIL ===");
      $fatal(1, "bound property failure");
    end else if (!rst && wb.valid) begin
      check_writeback();
    end
  end

  initial begin
    int total;
    // Filler decodes as a bubble since funct is 0
    for (int a = 0; a < 256; a++)
      imem[a[7:0]] = {16'h0000, a[7:0], 8'h00};
    for (int i = 0; i < REG_COUNT; i++)
      model_regs[i[4:0]] = word_t'(i);
    for (int i = 0; i < DMEM_WORDS; i++)
      model_mem[i[DMEM_AW-1:0]] = '0;
    prog_len = 0;
    build_alu_chains();
    build_load_use();
    build_store_load();
    build_branches();
    build_random();
    total = exp_q.size();
    wait_reset_release();
    for (int k = 0; k < prog_ends.size(); k++)
      wait_drain(prog_names[k], total - prog_ends[k]);
    repeat (8) @(posedge clk);  // Any stray beat shows up in these trailing cycles
    if (DUT.u_props.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("A property bound to cpu_top failed");
      $display("=== FAIL ===");
      $fatal(1, "bound property failure");
    end
  end

endmodule

/* verilog.f */
hdl/cpu_pkg.sv
hdl/pipe_stage_reg.sv
hdl/reg_file.sv
hdl/instr_decode.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/data_memory.sv
hdl/cpu_top.sv
sim/tb_clock.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

/* Makefile */
# Verilator flow for the pipelined core

VERILATOR ?= verilator
TOP       ?= cpu_tb
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

sim: build
	-$(BUILD)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
